/* isaPkg.sv */
package isaPkg;

  // Datapath sizes
  localparam int wordWidth    = 16;
  localparam int regAddrWidth = 4;  // Sixteen registers
  localparam int immWidth     = 8;  // LLB immediate
  localparam int flagWidth    = 3;

  // Reduced opcode set
  typedef enum logic [3:0] {
    opAdd = 4'b0000,
    opSub = 4'b0001,
    opAnd = 4'b0010,
    opXor = 4'b0011,
    opLw  = 4'b1000,
    opSw  = 4'b1001,
    opLlb = 4'b1010,
    opHlt = 4'b1111
  } opcodeT;

  // Instruction field positions
  localparam int opMsb  = 15;
  localparam int opLsb  = 12;
  localparam int rdMsb  = 11;
  localparam int rdLsb  = 8;
  localparam int rsMsb  = 7;
  localparam int rsLsb  = 4;
  localparam int rtMsb  = 3;   // Also LW/SW offset
  localparam int rtLsb  = 0;
  localparam int immMsb = 7;
  localparam int immLsb = 0;

  // Flag bits
  localparam int flagZ = 2;
  localparam int flagV = 1;
  localparam int flagN = 0;

endpackage

/* pipePkg.sv */
package pipePkg;

  // IF/ID
  typedef struct packed {
    logic                            valid;
    logic [isaPkg::wordWidth-1:0]    instr;
  } ifIdT;

  // ID/EX, control plus operands read in decode
  typedef struct packed {
    logic                            valid;
    isaPkg::opcodeT                  op;
    logic [isaPkg::regAddrWidth-1:0] rs;     // Zero when unused
    logic [isaPkg::regAddrWidth-1:0] rt;     // Zero when unused
    logic [isaPkg::regAddrWidth-1:0] rd;
    logic [isaPkg::wordWidth-1:0]    aData;
    logic [isaPkg::wordWidth-1:0]    bData;  // rt, or rd for SW
    logic [isaPkg::immWidth-1:0]     imm;
    logic                            regWrt;
    logic                            memRead;
    logic                            memWrt;
    logic                            halt;
  } idExT;

  // EX/MEM
  typedef struct packed {
    logic                            valid;
    logic [isaPkg::regAddrWidth-1:0] rd;
    logic [isaPkg::wordWidth-1:0]    res;        // ALU result or address
    logic [isaPkg::wordWidth-1:0]    storeData;
    logic                            regWrt;
    logic                            memRead;
    logic                            memWrt;
    logic                            halt;
  } exMemT;

  // MEM/WB
  typedef struct packed {
    logic                            valid;
    logic [isaPkg::regAddrWidth-1:0] rd;
    logic [isaPkg::wordWidth-1:0]    val;
    logic                            regWrt;
    logic                            halt;
  } memWbT;

  // EX operand source
  typedef enum logic [1:0] {
    fwdReg,
    fwdExMem,
    fwdMemWb
  } fwdSelT;

endpackage

/* hazardIf.sv */
interface hazardIf;
  import isaPkg::*;
  import pipePkg::*;

  // Decode sources, zero if not read
  logic [regAddrWidth-1:0] idRs;
  logic [regAddrWidth-1:0] idRt;

  // ID/EX
  logic [regAddrWidth-1:0] exRs;
  logic [regAddrWidth-1:0] exRt;
  logic [regAddrWidth-1:0] exRd;
  logic                    exRegWrt;
  logic                    exMemRead;

  // Older producers
  logic [regAddrWidth-1:0] memRd;
  logic                    memRegWrt;   // Forwardable result only
  logic [regAddrWidth-1:0] wbRd;
  logic                    wbRegWrt;

  // Unit outputs
  fwdSelT                  fwdA;
  fwdSelT                  fwdB;
  logic                    stall;

  modport pipe (
    output idRs, idRt, exRs, exRt, exRd, exRegWrt, exMemRead,
    output memRd, memRegWrt, wbRd, wbRegWrt,
    input  fwdA, fwdB, stall
  );

  modport unit (
    input  idRs, idRt, exRs, exRt, exRd, exRegWrt, exMemRead,
    input  memRd, memRegWrt, wbRd, wbRegWrt,
    output fwdA, fwdB, stall
  );

endinterface

/* wordMem.sv */
module wordMem #(
  parameter int addrWidth = 8
) (
  input  logic                         clk,
  input  logic                         wrEn,
  input  logic [addrWidth-1:0]         addr,
  input  logic [isaPkg::wordWidth-1:0] wrData,
  output logic [isaPkg::wordWidth-1:0] rdData
);
  import isaPkg::*;

  //////////////////////////////
  // Storage
  //////////////////////////////

  logic [wordWidth-1:0] mem [2**addrWidth];  // One word per address

  // Write lands at the edge
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[addr] <= wrData;
    end
  end

  // Async read, same address as write
  assign rdData = mem[addr];

endmodule

/* regFile.sv */
module regFile (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [isaPkg::regAddrWidth-1:0] rdAddrA,
  input  logic [isaPkg::regAddrWidth-1:0] rdAddrB,
  output logic [isaPkg::wordWidth-1:0]    rdDataA,
  output logic [isaPkg::wordWidth-1:0]    rdDataB,
  input  logic                            wrEn,
  input  logic [isaPkg::regAddrWidth-1:0] wrAddr,
  input  logic [isaPkg::wordWidth-1:0]    wrData
);
  import isaPkg::*;

  logic [wordWidth-1:0] regs [2**regAddrWidth];
  logic                 wrLive;   // Write that actually lands

  assign wrLive = wrEn && (wrAddr != '0);  // r0 stays zero

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Write-through so WB and ID can share a cycle
  assign rdDataA = (wrLive && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
  assign rdDataB = (wrLive && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

/* alu.sv */
module alu (
  input  isaPkg::opcodeT                op,
  input  logic [isaPkg::wordWidth-1:0]  a,
  input  logic [isaPkg::wordWidth-1:0]  b,
  input  logic [isaPkg::immWidth-1:0]   imm,
  output logic [isaPkg::wordWidth-1:0]  res,
  output logic [isaPkg::flagWidth-1:0]  flagsOut
);
  import isaPkg::*;

  localparam int msb      = wordWidth - 1;
  localparam int offWidth = rtMsb - rtLsb + 1;  // LW/SW offset bits

  logic ovfl;

  always_comb begin
    ovfl = 1'b0;
    case (op)
      opAdd: begin
        res  = a + b;
        ovfl = (a[msb] == b[msb]) && (res[msb] != a[msb]);  // Same signs in, flip out
      end
      opSub: begin
        res  = a - b;
        ovfl = (a[msb] != b[msb]) && (res[msb] != a[msb]);
      end
      opAnd: res = a & b;
      opXor: res = a ^ b;
      // Sign-extended byte
      opLlb: res = {{(wordWidth - immWidth){imm[immWidth-1]}}, imm};
      // Address, base plus zero-extended offset
      opLw, opSw: res = a + wordWidth'(imm[offWidth-1:0]);
      default: res = '0;  // HLT
    endcase

    // Raw flags, register picks per opcode
    flagsOut[flagZ] = (res == '0);
    flagsOut[flagV] = ovfl;
    flagsOut[flagN] = res[msb];
  end

endmodule

/* hazardUnit.sv */
module hazardUnit (
  hazardIf.unit hz
);
  import isaPkg::*;
  import pipePkg::*;

  // Operand source for one EX read
  function automatic fwdSelT pickSrc(
    input logic [regAddrWidth-1:0] src,
    input logic [regAddrWidth-1:0] memRd,
    input logic                    memRegWrt,
    input logic [regAddrWidth-1:0] wbRd,
    input logic                    wbRegWrt
  );
    if (src == '0) begin
      return fwdReg;  // r0 never forwarded
    end
    if (memRegWrt && (memRd == src)) begin
      return fwdExMem;  // Youngest producer first
    end
    if (wbRegWrt && (wbRd == src)) begin
      return fwdMemWb;  // Includes load data
    end
    return fwdReg;
  endfunction

  //////////////////////////////
  // Forwarding
  //////////////////////////////

  assign hz.fwdA = pickSrc(hz.exRs, hz.memRd, hz.memRegWrt, hz.wbRd, hz.wbRegWrt);
  assign hz.fwdB = pickSrc(hz.exRt, hz.memRd, hz.memRegWrt, hz.wbRd, hz.wbRegWrt);

  //////////////////////////////
  // Load-to-use
  //////////////////////////////

  // exRegWrt already excludes r0, unused sources arrive as zero
  assign hz.stall = hz.exMemRead && hz.exRegWrt &&
                    ((hz.exRd == hz.idRs) || (hz.exRd == hz.idRt));

endmodule

/* cpu.sv */
module cpu #(
  parameter int imemAddrWidth = 8,
  parameter int dmemAddrWidth = 8
) (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            imemWrEn,  // Program load, in reset only
  input  logic [imemAddrWidth-1:0]        imemAddr,
  input  logic [isaPkg::wordWidth-1:0]    imemData,
  output logic [isaPkg::wordWidth-1:0]    pc,
  output logic                            hlt,
  output logic [isaPkg::flagWidth-1:0]    flags,     // Z V N
  output logic                            wbEn,
  output logic [isaPkg::regAddrWidth-1:0] wbAddr,
  output logic [isaPkg::wordWidth-1:0]    wbData
);
  import isaPkg::*;
  import pipePkg::*;

  ifIdT  ifId;
  idExT  idEx;
  idExT  idNext;   // Decode result
  exMemT exMem;
  memWbT memWb;

  logic fetchOff;  // HLT seen in decode
  logic hltSeen;
  logic hltDecode;

  hazardIf hz ();

  function automatic logic [wordWidth-1:0] fwdMux(
    input fwdSelT               sel,
    input logic [wordWidth-1:0] regVal,
    input logic [wordWidth-1:0] exVal,
    input logic [wordWidth-1:0] wbVal
  );
    case (sel)
      fwdExMem: return exVal;
      fwdMemWb: return wbVal;
      default:  return regVal;
    endcase
  endfunction

  //////////////////////////////
  // IF
  //////////////////////////////

  logic [wordWidth-1:0]     instrIf;
  logic [imemAddrWidth-1:0] imemAddrSel;

  assign imemAddrSel = rstN ? pc[imemAddrWidth-1:0] : imemAddr;  // Loader owns port in reset

  wordMem #(.addrWidth(imemAddrWidth)) imem (
    .clk    (clk),
    .wrEn   (imemWrEn & ~rstN),
    .addr   (imemAddrSel),
    .wrData (imemData),
    .rdData (instrIf)
  );

  //////////////////////////////
  // ID
  //////////////////////////////

  opcodeT                  idOp;
  logic [regAddrWidth-1:0] idRd;
  logic [regAddrWidth-1:0] idRs;
  logic [regAddrWidth-1:0] idRt;
  logic [regAddrWidth-1:0] rdAddrB;
  logic [wordWidth-1:0]    rdDataA;
  logic [wordWidth-1:0]    rdDataB;
  logic                    useA;
  logic                    useB;

  assign idOp      = opcodeT'(ifId.instr[opMsb:opLsb]);
  assign idRd      = ifId.instr[rdMsb:rdLsb];
  assign idRs      = ifId.instr[rsMsb:rsLsb];
  assign idRt      = ifId.instr[rtMsb:rtLsb];
  assign rdAddrB   = (idOp == opSw) ? idRd : idRt;  // SW data lives in rd
  assign hltDecode = ifId.valid && (idOp == opHlt);

  regFile rf (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (idRs),
    .rdAddrB (rdAddrB),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB),
    .wrEn    (wbEn),
    .wrAddr  (wbAddr),
    .wrData  (wbData)
  );

  always_comb begin
    idNext = '0;
    useA   = 1'b0;
    useB   = 1'b0;
    case (idOp)
      opAdd, opSub, opAnd, opXor: begin
        useA          = 1'b1;
        useB          = 1'b1;
        idNext.regWrt = 1'b1;
      end
      opLlb: idNext.regWrt = 1'b1;  // No source reads
      opLw: begin
        useA           = 1'b1;
        idNext.regWrt  = 1'b1;
        idNext.memRead = 1'b1;
      end
      opSw: begin
        useA          = 1'b1;
        useB          = 1'b1;  // Store data
        idNext.memWrt = 1'b1;
      end
      opHlt: idNext.halt = 1'b1;
      default: ;
    endcase
    useA           = useA & ifId.valid;
    useB           = useB & ifId.valid;
    idNext.regWrt  = idNext.regWrt & (idRd != '0);  // r0 writes dropped here
    idNext.valid   = ifId.valid;
    idNext.op      = idOp;
    idNext.rs      = useA ? idRs : '0;
    idNext.rt      = useB ? rdAddrB : '0;
    idNext.rd      = idRd;
    idNext.aData   = rdDataA;
    idNext.bData   = rdDataB;
    idNext.imm     = ifId.instr[immMsb:immLsb];
  end

  //////////////////////////////
  // Hazard unit hookup
  //////////////////////////////

  assign hz.idRs      = idNext.rs;
  assign hz.idRt      = idNext.rt;
  assign hz.exRs      = idEx.rs;
  assign hz.exRt      = idEx.rt;
  assign hz.exRd      = idEx.rd;
  assign hz.exRegWrt  = idEx.valid & idEx.regWrt;
  assign hz.exMemRead = idEx.valid & idEx.memRead;
  assign hz.memRd     = exMem.rd;
  assign hz.memRegWrt = exMem.valid & exMem.regWrt & ~exMem.memRead;  // Load data not out yet
  assign hz.wbRd      = memWb.rd;
  assign hz.wbRegWrt  = wbEn;

  hazardUnit hzu (.hz(hz));

  //////////////////////////////
  // EX and MEM
  //////////////////////////////

  logic [wordWidth-1:0] opA;
  logic [wordWidth-1:0] opB;      // Also store data
  logic [wordWidth-1:0] aluRes;
  logic [flagWidth-1:0] aluFlags;
  logic [wordWidth-1:0] dmemRdData;
  logic [wordWidth-1:0] memVal;

  assign opA = fwdMux(hz.fwdA, idEx.aData, exMem.res, memWb.val);
  assign opB = fwdMux(hz.fwdB, idEx.bData, exMem.res, memWb.val);

  alu exAlu (
    .op       (idEx.op),
    .a        (opA),
    .b        (opB),
    .imm      (idEx.imm),
    .res      (aluRes),
    .flagsOut (aluFlags)
  );

  wordMem #(.addrWidth(dmemAddrWidth)) dmem (
    .clk    (clk),
    .wrEn   (exMem.valid & exMem.memWrt),
    .addr   (exMem.res[dmemAddrWidth-1:0]),
    .wrData (exMem.storeData),
    .rdData (dmemRdData)
  );

  assign memVal = exMem.memRead ? dmemRdData : exMem.res;

  //////////////////////////////
  // State
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc       <= '0;
      fetchOff <= 1'b0;
      hltSeen  <= 1'b0;
      ifId     <= '0;
      idEx     <= '0;
      exMem    <= '0;
      memWb    <= '0;
    end else begin
      if (!(hz.stall || hltDecode || fetchOff)) begin
        pc <= pc + wordWidth'(1);
      end
      if (!hz.stall) begin  // Stall holds PC and IF/ID
        ifId.valid <= !(hltDecode || fetchOff);  // Bubbles after HLT
        ifId.instr <= instrIf;
      end
      fetchOff <= fetchOff | hltDecode;
      hltSeen  <= hlt;
      if (hz.stall) begin
        idEx <= '0;  // Bubble
      end else begin
        idEx <= idNext;
      end
      exMem <= '{valid: idEx.valid, rd: idEx.rd, res: aluRes, storeData: opB,
                 regWrt: idEx.regWrt, memRead: idEx.memRead, memWrt: idEx.memWrt,
                 halt: idEx.halt};
      memWb <= '{valid: exMem.valid, rd: exMem.rd, val: memVal,
                 regWrt: exMem.regWrt, halt: exMem.halt};
    end
  end

  // Flags at end of EX, per opcode enables
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flags <= '0;
    end else if (idEx.valid) begin
      if (idEx.op inside {opAdd, opSub, opAnd, opXor}) begin
        flags[flagZ] <= aluFlags[flagZ];
      end
      if (idEx.op inside {opAdd, opSub}) begin  // Logic ops keep V and N
        flags[flagV] <= aluFlags[flagV];
        flags[flagN] <= aluFlags[flagN];
      end
    end
  end

  //////////////////////////////
  // WB
  //////////////////////////////

  assign wbEn   = memWb.valid & memWb.regWrt;
  assign wbAddr = memWb.rd;
  assign wbData = memWb.val;
  assign hlt    = hltSeen | (memWb.valid & memWb.halt);  // Sticky from HLT writeback

endmodule

/* cpuAssertions.sv */
module cpuAssertions (
  input logic                         clk,
  input logic                         rstN,
  input logic                         wbEn,
  input logic                         stall,
  input logic [isaPkg::wordWidth-1:0] pc,
  input logic                         hlt
);

  // No retire while held in reset
  quietInReset: assert property (@(posedge clk) !rstN |-> !wbEn)
    else $error("wbEn high while rstN is low");

  // One bubble per load-use pair
  singleStall: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
    else $error("stall held for two cycles");

  pcHeld: assert property (@(posedge clk) disable iff (!rstN) stall |=> $stable(pc))
    else $error("pc moved during a stall");

  // Sticky until reset
  hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
    else $error("hlt fell without reset");

endmodule

bind cpu cpuAssertions chk (
  .clk   (clk),
  .rstN  (rstN),
  .wbEn  (wbEn),
  .stall (hz.stall),
  .pc    (pc),
  .hlt   (hlt)
);

/* cpuTb.sv */
module cpuTb;
  import isaPkg::*;

  localparam int imemAw   = 8;
  localparam int dmemAw   = 8;
  localparam int resetLen = 16;  // Minimum reset cycles per program
  // Program lengths for chain, store/load, load-use, flags, halt and random
  localparam int progWords = 6 + 10 + 8 + 14 + 6 + 21;

  logic                    clk;
  logic                    rstN;
  logic                    imemWrEn;
  logic [imemAw-1:0]       imemAddr;
  logic [wordWidth-1:0]    imemData;
  logic [wordWidth-1:0]    pc;
  logic                    hlt;
  logic [flagWidth-1:0]    flags;
  logic                    wbEn;
  logic [regAddrWidth-1:0] wbAddr;
  logic [wordWidth-1:0]    wbData;

  logic [15:0] prog [$];      // Program under test
  logic [19:0] expQ [$];      // {rd, value} from the model
  logic [19:0] gotQ [$];      // {rd, value} seen on wb port
  logic [2:0]  expFlags;
  logic [15:0] modelRegs [16];
  logic [15:0] modelMem [256];
  int          seed;
  int          testErrs;
  int          totalErrs;
  int          failedTests;
  int          testsRun;

  cpu #(.imemAddrWidth(imemAw), .dmemAddrWidth(dmemAw)) dut (
    .clk(clk), .rstN(rstN), .imemWrEn(imemWrEn), .imemAddr(imemAddr),
    .imemData(imemData), .pc(pc), .hlt(hlt), .flags(flags),
    .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
  );

  always #50 clk = ~clk;

  //////////////////////////////
  // Encoders and ISA model
  //////////////////////////////

  function automatic logic [15:0] aluInstr(opcodeT op, int rd, int rs, int rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  function automatic logic [15:0] llbInstr(int rd, int imm);
    return {opLlb, 4'(rd), 8'(imm)};
  endfunction

  function automatic logic [15:0] memInstr(opcodeT op, int rd, int rs, int off);
    return {op, 4'(rd), 4'(rs), 4'(off)};  // rd is store data for SW
  endfunction

  // Executes prog in order, stops at HLT
  task automatic runModel();
    logic [15:0] instr;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic [7:0]  addr;
    logic [3:0]  rd;
    int          sum;
    bit          wr;
    bit          done;
    int          k;
    expQ.delete();
    expFlags = '0;
    foreach (modelRegs[i]) modelRegs[i] = '0;
    done = 0;
    k    = 0;
    while (!done && k < prog.size()) begin
      instr = prog[k];
      rd    = instr[11:8];
      a     = modelRegs[instr[7:4]];
      b     = modelRegs[instr[3:0]];
      addr  = a[7:0] + {4'h0, instr[3:0]};  // Data memory wraps at 256 words
      wr    = 1;
      r     = '0;
      case (instr[15:12])
        opAdd, opSub: begin
          if (instr[15:12] == opAdd) sum = int'($signed(a)) + int'($signed(b));
          else sum = int'($signed(a)) - int'($signed(b));
          r = sum[15:0];
          expFlags[flagV] = (sum > 32767) || (sum < -32768);  // Out of 16-bit range
          expFlags[flagN] = r[15];
          expFlags[flagZ] = (r == '0);
        end
        opAnd: begin
          r = a & b;
          expFlags[flagZ] = (r == '0);  // V, N kept
        end
        opXor: begin
          r = a ^ b;
          expFlags[flagZ] = (r == '0);
        end
        opLlb: r = {{8{instr[7]}}, instr[7:0]};
        opLw:  r = modelMem[addr];
        opSw: begin
          modelMem[addr] = modelRegs[rd];
          wr = 0;
        end
        opHlt: begin
          done = 1;
          wr   = 0;
        end
        default: wr = 0;
      endcase
      if (wr && rd != '0) begin  // r0 writes never show
        modelRegs[rd] = r;
        expQ.push_back({rd, r});
      end
      k++;
    end
  endtask

  //////////////////////////////
  // Drive and check
  //////////////////////////////

  // Loads prog in reset, then collects wb events until hlt
  task automatic loadAndRun();
    int resetCycles;
    resetCycles = (prog.size() > resetLen) ? prog.size() : resetLen;
    @(negedge clk);
    rstN = 1'b0;
    for (int i = 0; i < resetCycles; i++) begin
      imemWrEn = (i < prog.size());
      imemAddr = imemAw'(i);
      imemData = (i < prog.size()) ? prog[i] : '0;
      @(negedge clk);
    end
    imemWrEn = 1'b0;
    rstN     = 1'b1;
    gotQ.delete();
    while (!hlt) begin
      @(negedge clk);  // Outputs settled
      if (wbEn) gotQ.push_back({wbAddr, wbData});
    end
  endtask

  task automatic compareValue(string name, logic [31:0] expVal, logic [31:0] gotVal);
    assert (gotVal === expVal) else begin
      $display("ERROR %s expected %h got %h", name, expVal, gotVal);
      testErrs++;
    end
  endtask

  task automatic checkWriteback();
    int n;
    assert (gotQ.size() == expQ.size()) else begin
      $display("Wrong number of writebacks, expected %0d but saw %0d",
               expQ.size(), gotQ.size());
      testErrs++;
    end
    n = (gotQ.size() < expQ.size()) ? gotQ.size() : expQ.size();
    for (int i = 0; i < n; i++) begin
      compareValue($sformatf("wbAddr[%0d]", i), 32'(expQ[i][19:16]), 32'(gotQ[i][19:16]));
      compareValue($sformatf("wbData[%0d]", i), 32'(expQ[i][15:0]), 32'(gotQ[i][15:0]));
    end
    compareValue("flags", 32'(expFlags), 32'(flags));
  endtask

  task automatic closeTest(string name);
    if (testErrs == 0) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: failed with %0d errors", name, testErrs);
      failedTests++;
    end
    totalErrs += testErrs;
    testsRun++;
    testErrs = 0;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic forwardChain();
    prog.delete();
    prog.push_back(llbInstr(1, 5));
    prog.push_back(llbInstr(2, -3));
    prog.push_back(aluInstr(opAdd, 3, 1, 2));  // Needs both LLBs
    prog.push_back(aluInstr(opSub, 4, 3, 1));
    prog.push_back(aluInstr(opAdd, 5, 4, 4));
    prog.push_back({opHlt, 12'h000});
    runModel();
    loadAndRun();
    checkWriteback();
    closeTest("forwardChain");
  endtask

  task automatic storeThenLoad();
    prog.delete();
    prog.push_back(llbInstr(1, 8'h10));  // Base
    prog.push_back(llbInstr(2, 8'h7a));
    prog.push_back(memInstr(opSw, 2, 1, 2));  // Store data forwarded
    prog.push_back(memInstr(opLw, 3, 1, 2));
    prog.push_back(aluInstr(opAdd, 4, 3, 2));
    prog.push_back(llbInstr(5, -1));
    prog.push_back(memInstr(opSw, 5, 1, 3));
    prog.push_back(memInstr(opLw, 6, 1, 3));
    prog.push_back(aluInstr(opXor, 7, 6, 2));
    prog.push_back({opHlt, 12'h000});
    runModel();
    loadAndRun();
    checkWriteback();
    closeTest("storeThenLoad");
  endtask

  task automatic loadUseStall();
    prog.delete();
    prog.push_back(llbInstr(1, 8'h20));
    prog.push_back(llbInstr(2, 8'h33));
    prog.push_back(memInstr(opSw, 2, 1, 0));
    prog.push_back(memInstr(opLw, 3, 1, 0));
    prog.push_back(aluInstr(opAdd, 4, 3, 3));  // Stalls one cycle
    prog.push_back(memInstr(opLw, 5, 1, 0));
    prog.push_back(aluInstr(opSub, 6, 2, 5));  // Dependency on rt side
    prog.push_back({opHlt, 12'h000});
    runModel();
    loadAndRun();
    checkWriteback();
    closeTest("loadUseStall");
  endtask

  task automatic flagUpdates();
    prog.delete();
    prog.push_back(llbInstr(1, 8'h7f));
    repeat (8) prog.push_back(aluInstr(opAdd, 1, 1, 1));  // Up to 0x7f00
    prog.push_back(aluInstr(opSub, 3, 1, 1));  // Zero
    prog.push_back(aluInstr(opAdd, 2, 1, 1));  // Signed overflow
    prog.push_back(aluInstr(opAnd, 5, 2, 1));
    prog.push_back(aluInstr(opXor, 4, 1, 1));  // Z set, V and N stay
    prog.push_back({opHlt, 12'h000});
    runModel();
    loadAndRun();
    checkWriteback();
    closeTest("flagUpdates");
  endtask

  task automatic haltFreeze();
    logic [15:0] holdPc;
    prog.delete();
    prog.push_back(llbInstr(1, 9));
    prog.push_back(aluInstr(opAdd, 2, 1, 1));
    prog.push_back({opHlt, 12'h000});
    prog.push_back(llbInstr(3, 1));  // Must never retire
    prog.push_back(aluInstr(opAdd, 4, 1, 1));
    prog.push_back(llbInstr(5, 2));
    runModel();
    loadAndRun();
    checkWriteback();
    holdPc = 16'(3);  // Fetch address just past the HLT at word 2
    repeat (10) begin
      @(negedge clk);
      compareValue("pc", 32'(holdPc), 32'(pc));
      compareValue("hlt", 32'(1'b1), 32'(hlt));
      assert (!wbEn) else begin
        $display("Writeback to register %0d after halt", wbAddr);
        testErrs++;
      end
    end
    closeTest("haltFreeze");
  endtask

  task automatic randomAluProgram();
    opcodeT ops [5];
    opcodeT op;
    int     r;
    ops = '{opAdd, opSub, opAnd, opXor, opLlb};
    prog.delete();
    repeat (20) begin
      r  = $random(seed);
      op = ops[((r >> 24) & 255) % 5];
      if (op == opLlb) begin
        prog.push_back(llbInstr((r >> 4) & 7, (r >> 16) & 255));
      end else begin
        prog.push_back(aluInstr(op, (r >> 4) & 7, (r >> 8) & 7, (r >> 12) & 7));  // r0 included
      end
    end
    prog.push_back({opHlt, 12'h000});
    runModel();
    loadAndRun();
    checkWriteback();
    closeTest("randomAluProgram");
  endtask

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////

  initial begin
    clk         = 1'b0;
    rstN        = 1'b0;
    imemWrEn    = 1'b0;
    imemAddr    = '0;
    imemData    = '0;
    seed        = 32'h52e25681;
    testErrs    = 0;
    totalErrs   = 0;
    failedTests = 0;
    testsRun    = 0;
    forwardChain();
    storeThenLoad();
    loadUseStall();
    flagUpdates();
    haltFreeze();
    randomAluProgram();
    $display("Tests run %0d, failed %0d, errors %0d", testsRun, failedTests, totalErrs);
    if (totalErrs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    repeat ((progWords + 20) * 6) @(posedge clk);
    $display("Timeout, the tests did not complete in %0d cycles", (progWords + 20) * 6);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* files.f */
isaPkg.sv
pipePkg.sv
hazardIf.sv
wordMem.sv
regFile.sv
alu.sv
hazardUnit.sv
cpu.sv
cpuAssertions.sv
cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module cpuTb -o simCpu

./obj_dir/simCpu | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation reported failures, see sim.log"
  exit 1
fi
echo "Simulation run complete"
